// File: ervp_timer_subsys.f
verilog/ervp_timer_pkg.sv
verilog/us_tick_gen.sv
verilog/timer_apb_regs.sv
verilog/timer_core.sv
verilog/ervp_timer_subsys.sv
dv/tb_clk_gen.sv
dv/ervp_timer_subsys_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log for the fail message

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
	--top-module ervp_timer_subsys_tb \
	-f ervp_timer_subsys.f \
	-Mdir obj_dir > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vervp_timer_subsys_tb > sim.log 2>&1
cat sim.log

grep -q "STATUS: FAIL" sim.log && { echo "Simulation reported failure"; exit 1; }
exit 0

// File: dv/ervp_timer_subsys_tb.sv
module ervp_timer_subsys_tb
	import ervp_timer_pkg::*;
();

	localparam int CLK_PERIOD = 10;
	localparam int BW_ADDR_TB = 8;
	localparam int CLK_PER_US_TB = 4;
	localparam int NOW_DELAY = 40;
	localparam int N_REPEAT = 4;
	localparam int N_MIX = 3;
	localparam int WD_MARGIN = 5000;

	localparam logic [31:0] CMD_ONE_SHOT = (32'd1 << CMD_PER_SET) | (32'd1 << CMD_PER_EN);
	localparam logic [31:0] CMD_PER_LOOP = CMD_ONE_SHOT | (32'd1 << CMD_PER_REPEAT);
	localparam logic [31:0] CMD_PER_STOP = 32'd1 << CMD_PER_SET;
	localparam logic [31:0] CMD_DLY_ARM = (32'd1 << CMD_DLY_SET) | (32'd1 << CMD_DLY_EN);
	localparam logic [31:0] CMD_DLY_STOP = 32'd1 << CMD_DLY_SET;

	logic clk;
	logic rstnn;
	logic psel;
	logic penable;
	logic [BW_ADDR_TB-1:0] paddr;
	logic pwrite;
	logic [BW_DATA-1:0] pwdata;
	logic [BW_DATA-1:0] prdata;
	logic pready;
	logic pslverr;
	logic timer_interrupt;
	logic delay_notice;

	logic [31:0] rng_state;
	longint cyc = 0;
	longint wr_done_cyc;
	longint wd_limit = 0;

	tb_clk_gen #(
		.PERIOD(CLK_PERIOD),
		.RESET_CYCLES(4)
	) u_clk_gen (
		.clk(clk),
		.rstnn(rstnn)
	);

	ervp_timer_subsys #(
		.BW_ADDR(BW_ADDR_TB),
		.CLK_PER_US(CLK_PER_US_TB)
	) u_ervp_timer_subsys (
		.clk(clk),
		.rstnn(rstnn),
		.psel(psel),
		.penable(penable),
		.paddr(paddr),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.timer_interrupt(timer_interrupt),
		.delay_notice(delay_notice)
	);

	// Cycle count, read only on the falling edge
	always @(posedge clk)
		cyc <= cyc + 1;

	// ************************************************************************
	// Failure reporting
	// ************************************************************************

	task automatic stop_with_failure();
		$display("STATUS: FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic fail_value(input string sig, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		$display("ERR time=%0t signal=%s expected=0x%08h actual=0x%08h",
			$time, sig, exp_val, act_val);
		stop_with_failure();
	endtask

	task automatic fail_event(input string what);
		$display("Error at time %0t: %s", $time, what);
		stop_with_failure();
	endtask

	// ************************************************************************
	// Random intervals
	// ************************************************************************

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic draw_word(output logic [31:0] w);
		rng_state = xorshift32(rng_state);
		w = rng_state;
	endtask

	// Small intervals, 3 to 8 microseconds
	task automatic draw_interval(output int ticks);
		rng_state = xorshift32(rng_state);
		ticks = 3 + int'(rng_state % 32'd6);
	endtask

	// ************************************************************************
	// APB master
	// ************************************************************************

	task automatic write_reg(input int addr, input logic [31:0] data, input logic exp_err);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		paddr = BW_ADDR_TB'(addr);
		pwrite = 1'b1;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		#1;
		assert (pready === 1'b1) else fail_value("pready", 32'd1, 32'(pready));
		assert (pslverr === exp_err) else fail_value("pslverr", 32'(exp_err), 32'(pslverr));
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		wr_done_cyc = cyc;
	endtask

	task automatic read_reg(input int addr, input logic exp_err, output logic [31:0] data);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		paddr = BW_ADDR_TB'(addr);
		pwrite = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		#1;
		data = prdata;
		assert (pready === 1'b1) else fail_value("pready", 32'd1, 32'(pready));
		assert (pslverr === exp_err) else fail_value("pslverr", 32'(exp_err), 32'(pslverr));
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic expect_read(input int addr, input string name, input logic [31:0] exp_val);
		logic [31:0] data;
		read_reg(addr, 1'b0, data);
		assert (data === exp_val) else fail_value(name, exp_val, data);
	endtask

	// ************************************************************************
	// Event waits and timing checks
	// ************************************************************************

	task automatic wait_for_irq(input int max_cycles, output longint rise_cyc);
		int waited;
		waited = 0;
		while (timer_interrupt !== 1'b1)
		begin
			if (waited >= max_cycles)
				fail_event("timer_interrupt did not rise before its timeout");
			else
			begin
				@(negedge clk);
				waited++;
			end
		end
		rise_cyc = cyc;
	endtask

	// Also checks that the pulse is gone one cycle later
	task automatic wait_for_notice(input int max_cycles, output longint rise_cyc);
		int waited;
		waited = 0;
		while (delay_notice !== 1'b1)
		begin
			if (waited >= max_cycles)
				fail_event("delay_notice did not rise before its timeout");
			else
			begin
				@(negedge clk);
				waited++;
			end
		end
		rise_cyc = cyc;
		@(negedge clk);
		assert (delay_notice === 1'b0) else fail_value("delay_notice", 32'd0, 32'(delay_notice));
	endtask

	// Tick phase is free-running, so one tick of slack each way
	task automatic check_window(input string what, input longint elapsed, input int ticks);
		longint lo;
		longint hi;
		lo = longint'((ticks - 1) * CLK_PER_US_TB);
		hi = longint'((ticks + 1) * CLK_PER_US_TB);
		assert (elapsed >= lo && elapsed <= hi)
		else fail_event($sformatf("%s rose %0d cycles after arming, allowed %0d to %0d",
			what, elapsed, lo, hi));
	endtask

	task automatic quiet_irq(input int cycles);
		repeat (cycles)
		begin
			@(negedge clk);
			assert (timer_interrupt === 1'b0)
			else fail_value("timer_interrupt", 32'd0, 32'(timer_interrupt));
		end
	endtask

	// ************************************************************************
	// Protocol properties
	// ************************************************************************

	assert property (@(posedge clk) disable iff (!rstnn) (psel && penable) |-> pready)
	else fail_value("pready", 32'd1, 32'(pready));

	assert property (@(posedge clk) disable iff (!rstnn) !(psel && penable) |-> !pslverr)
	else fail_value("pslverr", 32'd0, 32'(pslverr));

	assert property (@(posedge clk) disable iff (!rstnn) delay_notice |=> !delay_notice)
	else fail_value("delay_notice", 32'd0, 32'(delay_notice));

	// Watchdog, limit set once the intervals are drawn
	initial
	begin
		wait (wd_limit != 0);
		#(wd_limit);
		fail_event("watchdog expired before the test sequence finished");
	end

	// ************************************************************************
	// Test sequence
	// ************************************************************************

	initial
	begin
		logic [31:0] word_a;
		logic [31:0] word_b;
		logic [31:0] rd;
		logic [31:0] first_now;
		longint arm_cyc;
		longint arm_dly;
		longint rise;
		longint prev_rise;
		int per_one;
		int per_rep;
		int per_mix;
		int dly_one;
		int dly_mix;

		psel = 1'b0;
		penable = 1'b0;
		paddr = '0;
		pwrite = 1'b0;
		pwdata = '0;

		rng_state = 32'h1df0;
		draw_word(word_a);
		draw_word(word_b);
		draw_interval(per_one);
		draw_interval(per_rep);
		draw_interval(per_mix);
		draw_interval(dly_one);
		draw_interval(dly_mix);
		wd_limit = longint'(NOW_DELAY + 3 * per_one + (N_REPEAT + 3) * per_rep + 2 * dly_one
			+ dly_mix + (N_MIX + 1) * per_mix) * CLK_PER_US_TB * CLK_PERIOD + WD_MARGIN;

		wait (rstnn === 1'b1);
		@(negedge clk);

		// Reset state
		assert (timer_interrupt === 1'b0) else fail_value("timer_interrupt", 0, 32'(timer_interrupt));
		assert (delay_notice === 1'b0) else fail_value("delay_notice", 0, 32'(delay_notice));
		assert (pslverr === 1'b0) else fail_value("pslverr", 0, 32'(pslverr));
		expect_read(ADDR_STATUS, "prdata STATUS", 32'd0);
		expect_read(ADDR_PERIOD, "prdata PERIOD", 32'd0);
		expect_read(ADDR_DELAY, "prdata DELAY", 32'd0);

		// Register access, then illegal accesses that must not disturb it
		write_reg(ADDR_PERIOD, word_a, 1'b0);
		write_reg(ADDR_DELAY, word_b, 1'b0);
		expect_read(ADDR_PERIOD, "prdata PERIOD", word_a);
		expect_read(ADDR_DELAY, "prdata DELAY", word_b);
		read_reg(24, 1'b1, rd);
		write_reg(64, 32'hffff_ffff, 1'b1);
		write_reg(ADDR_STATUS, 32'hffff_ffff, 1'b1);
		write_reg(ADDR_NOW, 32'h1234_5678, 1'b1);
		expect_read(ADDR_PERIOD, "prdata PERIOD", word_a);
		expect_read(ADDR_DELAY, "prdata DELAY", word_b);
		expect_read(ADDR_STATUS, "prdata STATUS", 32'd0);
		expect_read(ADDR_NOW, "prdata NOW", 32'd0);

		// NOW runs once a channel is active
		write_reg(ADDR_DELAY, 32'(NOW_DELAY), 1'b0);
		write_reg(ADDR_CMD, CMD_DLY_ARM, 1'b0);
		read_reg(ADDR_NOW, 1'b0, first_now);
		repeat (3 * CLK_PER_US_TB) @(negedge clk);
		read_reg(ADDR_NOW, 1'b0, rd);
		assert (rd > first_now)
		else fail_event($sformatf("NOW did not advance, first read %0d, second read %0d",
			first_now, rd));
		write_reg(ADDR_CMD, CMD_DLY_STOP, 1'b0);
		expect_read(ADDR_STATUS, "prdata STATUS", 32'd0);

		// One-shot periodic interrupt
		write_reg(ADDR_PERIOD, 32'(per_one), 1'b0);
		write_reg(ADDR_CMD, CMD_ONE_SHOT, 1'b0);
		arm_cyc = wr_done_cyc;
		wait_for_irq((per_one + 2) * CLK_PER_US_TB, rise);
		check_window("timer_interrupt", rise - arm_cyc, per_one);
		expect_read(ADDR_STATUS, "prdata STATUS", 32'd1 << ST_IRQ);
		write_reg(ADDR_IRQ_CLEAR, 32'd1, 1'b0);
		expect_read(ADDR_STATUS, "prdata STATUS", 32'd0);
		quiet_irq(2 * per_one * CLK_PER_US_TB);

		// Repeat mode, cleared after every assertion
		write_reg(ADDR_PERIOD, 32'(per_rep), 1'b0);
		write_reg(ADDR_CMD, CMD_PER_LOOP, 1'b0);
		arm_cyc = wr_done_cyc;
		wait_for_irq((per_rep + 2) * CLK_PER_US_TB, rise);
		check_window("timer_interrupt", rise - arm_cyc, per_rep);
		prev_rise = rise;
		write_reg(ADDR_IRQ_CLEAR, 32'd1, 1'b0);
		for (int i = 0; i < N_REPEAT; i++)
		begin
			wait_for_irq((per_rep + 2) * CLK_PER_US_TB, rise);
			assert ((rise - prev_rise) == longint'(per_rep * CLK_PER_US_TB))
			else fail_value("timer_interrupt spacing", 32'(per_rep * CLK_PER_US_TB),
				32'(rise - prev_rise));
			prev_rise = rise;
			write_reg(ADDR_IRQ_CLEAR, 32'd1, 1'b0);
		end
		write_reg(ADDR_CMD, CMD_PER_STOP, 1'b0);
		expect_read(ADDR_STATUS, "prdata STATUS", 32'd0);
		quiet_irq(2 * per_rep * CLK_PER_US_TB);

		// Delay notice alone
		write_reg(ADDR_DELAY, 32'(dly_one), 1'b0);
		write_reg(ADDR_CMD, CMD_DLY_ARM, 1'b0);
		arm_dly = wr_done_cyc;
		expect_read(ADDR_STATUS, "prdata STATUS", 32'd1 << ST_DLY_ACTIVE);
		wait_for_notice((dly_one + 2) * CLK_PER_US_TB, rise);
		check_window("delay_notice", rise - arm_dly, dly_one);
		expect_read(ADDR_STATUS, "prdata STATUS", 32'd0);

		// Delay and repeating periodic channel side by side
		write_reg(ADDR_PERIOD, 32'(per_mix), 1'b0);
		write_reg(ADDR_DELAY, 32'(dly_mix), 1'b0);
		write_reg(ADDR_CMD, CMD_PER_LOOP, 1'b0);
		arm_cyc = wr_done_cyc;
		write_reg(ADDR_CMD, CMD_DLY_ARM, 1'b0);
		arm_dly = wr_done_cyc;
		fork
			begin
				longint n_rise;
				wait_for_notice((dly_mix + 3) * CLK_PER_US_TB, n_rise);
				check_window("delay_notice", n_rise - arm_dly, dly_mix);
			end
			begin
				longint p_rise;
				longint p_prev;
				wait_for_irq((per_mix + 2) * CLK_PER_US_TB, p_rise);
				check_window("timer_interrupt", p_rise - arm_cyc, per_mix);
				p_prev = p_rise;
				write_reg(ADDR_IRQ_CLEAR, 32'd1, 1'b0);
				for (int i = 1; i < N_MIX; i++)
				begin
					wait_for_irq((per_mix + 2) * CLK_PER_US_TB, p_rise);
					assert ((p_rise - p_prev) == longint'(per_mix * CLK_PER_US_TB))
					else fail_value("timer_interrupt spacing", 32'(per_mix * CLK_PER_US_TB),
						32'(p_rise - p_prev));
					p_prev = p_rise;
					write_reg(ADDR_IRQ_CLEAR, 32'd1, 1'b0);
				end
			end
		join
		write_reg(ADDR_CMD, CMD_PER_STOP, 1'b0);
		expect_read(ADDR_STATUS, "prdata STATUS", 32'd0);

		$display("STATUS: PASS");
		$finish;
	end

endmodule

// File: dv/tb_clk_gen.sv
module tb_clk_gen
#(
	parameter int PERIOD = 10,
	parameter int RESET_CYCLES = 4
)
(
	output logic clk,
	output logic rstnn
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;
	end

	// Reset drops away from the rising edge
	initial
	begin
		rstnn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rstnn = 1'b1;
	end

endmodule

// File: verilog/ervp_timer_subsys.sv
module ervp_timer_subsys
	import ervp_timer_pkg::*;
#(
	parameter int BW_ADDR = 8,
	parameter int CLK_PER_US = 50
)
(
	input  logic clk,
	input  logic rstnn,

	input  logic psel,
	input  logic penable,
	input  logic [BW_ADDR-1:0] paddr,
	input  logic pwrite,
	input  logic [BW_DATA-1:0] pwdata,
	output logic [BW_DATA-1:0] prdata,
	output logic pready,
	output logic pslverr,

	output logic timer_interrupt,
	output logic delay_notice
);

	logic tick_us;

	logic [BW_DATA-1:0] period_val;
	logic [BW_DATA-1:0] delay_val;
	logic cmd_wr;
	logic [BW_CMD-1:0] cmd_bits;
	logic irq_clr;

	logic per_active;
	logic dly_active;
	logic irq;
	logic [BW_DATA-1:0] now_val;

	// Free-running microsecond tick
	us_tick_gen #(
		.CLK_PER_US(CLK_PER_US)
	) u_tick_gen (
		.clk(clk),
		.rstnn(rstnn),
		.tick_us(tick_us)
	);

	timer_apb_regs #(
		.BW_ADDR(BW_ADDR)
	) u_regs (
		.clk(clk),
		.rstnn(rstnn),
		.psel(psel),
		.penable(penable),
		.paddr(paddr),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.period_val(period_val),
		.delay_val(delay_val),
		.cmd_wr(cmd_wr),
		.cmd_bits(cmd_bits),
		.irq_clr(irq_clr),
		.per_active(per_active),
		.dly_active(dly_active),
		.irq(irq),
		.now_val(now_val)
	);

	// Counter and both compare channels
	timer_core u_core (
		.clk(clk),
		.rstnn(rstnn),
		.tick_us(tick_us),
		.period_val(period_val),
		.delay_val(delay_val),
		.cmd_wr(cmd_wr),
		.cmd_bits(cmd_bits),
		.irq_clr(irq_clr),
		.per_active(per_active),
		.dly_active(dly_active),
		.irq(irq),
		.now_val(now_val),
		.timer_interrupt(timer_interrupt),
		.delay_notice(delay_notice)
	);

endmodule

// File: verilog/timer_core.sv
module timer_core
	import ervp_timer_pkg::*;
(
	input  logic clk,
	input  logic rstnn,
	input  logic tick_us,

	input  logic [BW_DATA-1:0] period_val,
	input  logic [BW_DATA-1:0] delay_val,
	input  logic cmd_wr,
	input  logic [BW_CMD-1:0] cmd_bits,
	input  logic irq_clr,

	output logic per_active,
	output logic dly_active,
	output logic irq,
	output logic [BW_DATA-1:0] now_val,

	output logic timer_interrupt,
	output logic delay_notice
);

	logic per_set;
	logic dly_set;
	logic per_repeat;
	logic per_match;
	logic dly_match;

	logic [BW_DATA-1:0] per_target;
	logic [BW_DATA-1:0] dly_target;

	assign per_set = cmd_wr & cmd_bits[CMD_PER_SET];
	assign dly_set = cmd_wr & cmd_bits[CMD_DLY_SET];

	// ************************************************************************
	// Microsecond counter
	// ************************************************************************

	// Runs only while some channel needs it, wraps at full width
	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			now_val <= '0;
		else if (tick_us && (per_active || dly_active))
			now_val <= now_val + BW_DATA'(1);
	end

	// ************************************************************************
	// Periodic channel
	// ************************************************************************

	assign per_match = per_active & (now_val == per_target);

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			per_active <= 1'b0;
			per_repeat <= 1'b0;
		end
		else if (per_set)
		begin
			per_active <= cmd_bits[CMD_PER_EN];
			per_repeat <= cmd_bits[CMD_PER_REPEAT];
		end
		else if (per_match && !per_repeat)
			per_active <= 1'b0;
	end

	// Reload from the match value itself, so repeat spacing stays exact
	always_ff @(posedge clk)
	begin
		if (per_set || per_match)
			per_target <= now_val + period_val;
	end

	// A fresh match wins over a clear in the same cycle
	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			timer_interrupt <= 1'b0;
		else if (per_match)
			timer_interrupt <= 1'b1;
		else if (irq_clr)
			timer_interrupt <= 1'b0;
	end

	assign irq = timer_interrupt;

	// ************************************************************************
	// Delay channel
	// ************************************************************************

	assign dly_match = dly_active & (now_val == dly_target);

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			dly_active <= 1'b0;
		else if (dly_set)
			dly_active <= cmd_bits[CMD_DLY_EN];
		else if (dly_match)
			dly_active <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (dly_set)
			dly_target <= now_val + delay_val;
	end

	// Single-cycle pulse; any command write cancels it
	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			delay_notice <= 1'b0;
		else if (cmd_wr)
			delay_notice <= 1'b0;
		else if (delay_notice)
			delay_notice <= 1'b0;
		else if (dly_match)
			delay_notice <= 1'b1;
	end

endmodule

// File: verilog/timer_apb_regs.sv
module timer_apb_regs
	import ervp_timer_pkg::*;
#(
	parameter int BW_ADDR = 8
)
(
	input  logic clk,
	input  logic rstnn,

	input  logic psel,
	input  logic penable,
	input  logic [BW_ADDR-1:0] paddr,
	input  logic pwrite,
	input  logic [BW_DATA-1:0] pwdata,
	output logic [BW_DATA-1:0] prdata,
	output logic pready,
	output logic pslverr,

	output logic [BW_DATA-1:0] period_val,
	output logic [BW_DATA-1:0] delay_val,
	output logic cmd_wr,
	output logic [BW_CMD-1:0] cmd_bits,
	output logic irq_clr,

	input  logic per_active,
	input  logic dly_active,
	input  logic irq,
	input  logic [BW_DATA-1:0] now_val
);

	logic access;
	logic wr_access;
	logic rd_access;

	logic sel_period;
	logic sel_delay;
	logic sel_cmd;
	logic sel_status;
	logic sel_irq_clear;
	logic sel_now;

	logic mapped;
	logic read_only;

	logic [BW_DATA-1:0] status_word;

	// ************************************************************************
	// Access phase decode
	// ************************************************************************

	assign access = psel & penable;
	assign wr_access = access & pwrite;
	assign rd_access = access & ~pwrite;

	assign sel_period = (paddr == BW_ADDR'(ADDR_PERIOD));
	assign sel_delay = (paddr == BW_ADDR'(ADDR_DELAY));
	assign sel_cmd = (paddr == BW_ADDR'(ADDR_CMD));
	assign sel_status = (paddr == BW_ADDR'(ADDR_STATUS));
	assign sel_irq_clear = (paddr == BW_ADDR'(ADDR_IRQ_CLEAR));
	assign sel_now = (paddr == BW_ADDR'(ADDR_NOW));

	assign mapped = sel_period | sel_delay | sel_cmd | sel_status | sel_irq_clear | sel_now;
	assign read_only = sel_status | sel_now;

	// Zero wait states, every access completes here
	assign pready = access;
	assign pslverr = access & (~mapped | (pwrite & read_only));

	// ************************************************************************
	// Interval registers
	// ************************************************************************

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			period_val <= '0;
		else if (wr_access && sel_period)
			period_val <= pwdata;
	end

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			delay_val <= '0;
		else if (wr_access && sel_delay)
			delay_val <= pwdata;
	end

	// Command strobes, valid only in the access cycle
	assign cmd_wr = wr_access & sel_cmd;
	assign cmd_bits = pwdata[BW_CMD-1:0];
	assign irq_clr = wr_access & sel_irq_clear;

	// ************************************************************************
	// Read path
	// ************************************************************************

	always_comb
	begin
		status_word = '0;
		status_word[ST_PER_ACTIVE] = per_active;
		status_word[ST_DLY_ACTIVE] = dly_active;
		status_word[ST_IRQ] = irq;
	end

	// Write-only offsets read as zero
	always_comb
	begin
		prdata = '0;
		if (rd_access)
		begin
			if (sel_period)
				prdata = period_val;
			else if (sel_delay)
				prdata = delay_val;
			else if (sel_status)
				prdata = status_word;
			else if (sel_now)
				prdata = now_val;
		end
	end

endmodule

// File: verilog/us_tick_gen.sv
module us_tick_gen
#(
	parameter int CLK_PER_US = 50
)
(
	input  logic clk,
	input  logic rstnn,
	output logic tick_us
);

	// One extra bit keeps the width nonzero when CLK_PER_US is 1
	localparam int BW_CNT = $clog2(CLK_PER_US + 1);
	localparam logic [BW_CNT-1:0] CNT_LOAD = BW_CNT'(CLK_PER_US - 1);

	logic [BW_CNT-1:0] cnt;

	// Down-counter, reloads after reaching zero
	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			cnt <= CNT_LOAD;
		else if (cnt == '0)
			cnt <= CNT_LOAD;
		else
			cnt <= cnt - 1'b1;
	end

	// High for exactly one cycle out of every CLK_PER_US
	assign tick_us = (cnt == '0);

endmodule

// File: verilog/ervp_timer_pkg.sv
package ervp_timer_pkg;

	// ************************************************************************
	// Widths
	// ************************************************************************

	// APB data bus and microsecond counter share one width
	localparam int BW_DATA = 32;

	// Command field carried from the register block to the core
	localparam int BW_CMD = 5;

	// ************************************************************************
	// Register map, byte offsets on the APB bus
	// ************************************************************************

	// Periodic interval in microseconds, read/write
	localparam int ADDR_PERIOD = 0;

	// Delay length in microseconds, read/write
	localparam int ADDR_DELAY = 4;

	// Command word, write only
	localparam int ADDR_CMD = 8;

	// Channel and interrupt state, read only
	localparam int ADDR_STATUS = 12;

	// Any write drops timer_interrupt
	localparam int ADDR_IRQ_CLEAR = 16;

	// Current microsecond count, read only
	localparam int ADDR_NOW = 20;

	// ************************************************************************
	// CMD bit positions
	// ************************************************************************

	// Periodic channel takes new enable and repeat values
	localparam int CMD_PER_SET = 0;
	localparam int CMD_PER_EN = 1;
	localparam int CMD_PER_REPEAT = 2;

	// Delay channel takes a new enable value
	localparam int CMD_DLY_SET = 3;
	localparam int CMD_DLY_EN = 4;

	// ************************************************************************
	// STATUS bit positions
	// ************************************************************************

	localparam int ST_PER_ACTIVE = 0;
	localparam int ST_DLY_ACTIVE = 1;
	localparam int ST_IRQ = 2;

endpackage
